// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  // datapath and address width
  localparam int xlen = 32;
  // register index width
  localparam int reg_addr_w = 5;

  // pc advance per instruction
  localparam logic [xlen-1:0] word_step = 32'd4;

  // funct3 codes, alu classes
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  // funct3 codes, branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  // one instruction walks through these, always back to fetch
  typedef enum logic [3:0] {
    st_fetch,
    st_decode,
    st_mem_adr,
    st_mem_read,
    st_mem_wb,
    st_mem_write,
    st_exec_r,
    st_exec_i,
    st_alu_wb,
    st_branch,
    st_jal,
    st_lui
  } state_t;

  // memory address source
  typedef enum logic [0:0] {adr_pc, adr_result} adr_src_t;

  // alu operand selects
  typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rd1, src_a_zero} alu_src_a_t;
  typedef enum logic [1:0] {src_b_rd2, src_b_imm, src_b_four} alu_src_b_t;

  // writeback and address result select
  typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_src_t;

endpackage

`default_nettype wire

// File: design/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     pc_update,
  input  logic                     ir_write,
  input  logic [core_pkg::xlen-1:0] pc_next,
  input  logic [core_pkg::xlen-1:0] read_data,
  output logic [core_pkg::xlen-1:0] pc_cur,
  output logic [core_pkg::xlen-1:0] pc_old,
  output logic [core_pkg::xlen-1:0] instr
);

  // jump or branch target wins over the sequential step
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_cur <= '0;
    end else if (pc_update) begin
      pc_cur <= pc_next;
    end else if (ir_write) begin
      pc_cur <= pc_cur + core_pkg::word_step;
    end
  end

  // instruction and its own address, held for the whole sequence
  always_ff @(posedge clk) begin
    if (ir_write) begin
      instr  <= read_data;
      pc_old <= pc_cur;
    end
  end

  // targets come from the alu, so misalignment would show up here
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc_cur[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc_cur);

endmodule

`default_nettype wire

// File: design/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  logic [core_pkg::xlen-1:0]       instr,
  output core_pkg::opcode_t               opcode,
  output logic [2:0]                      funct3,
  output core_pkg::alu_op_t               alu_op,
  output logic [core_pkg::xlen-1:0]       imm_ext,
  output logic [core_pkg::reg_addr_w-1:0] rs1,
  output logic [core_pkg::reg_addr_w-1:0] rs2,
  output logic [core_pkg::reg_addr_w-1:0] rd
);

  // fixed field positions
  assign opcode = core_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediate format by opcode
  always_comb begin
    case (opcode)
      core_pkg::op_imm, core_pkg::op_load:
        imm_ext = {{20{instr[31]}}, instr[31:20]};
      core_pkg::op_store:
        imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // b type, bit 0 implied
      core_pkg::op_branch:
        imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      core_pkg::op_jal:
        imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      core_pkg::op_lui:
        imm_ext = {instr[31:12], 12'b0};
      default:
        imm_ext = '0;
    endcase
  end

  // alu operation by class
  always_comb begin
    alu_op = core_pkg::alu_add;
    case (opcode)
      core_pkg::op_reg, core_pkg::op_imm: begin
        case (funct3)
          // sub only for register form with funct7 bit 5
          core_pkg::f3_add_sub: alu_op = (opcode == core_pkg::op_reg && instr[30]) ?
                                         core_pkg::alu_sub : core_pkg::alu_add;
          core_pkg::f3_slt: alu_op = core_pkg::alu_slt;
          core_pkg::f3_or:  alu_op = core_pkg::alu_or;
          core_pkg::f3_and: alu_op = core_pkg::alu_and;
          default:          alu_op = core_pkg::alu_add;
        endcase
      end
      // compare by subtraction
      core_pkg::op_branch: alu_op = core_pkg::alu_sub;
      // address and link cases stay add
      default: alu_op = core_pkg::alu_add;
    endcase
  end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [core_pkg::reg_addr_w-1:0] addr1,
  input  logic [core_pkg::reg_addr_w-1:0] addr2,
  input  logic [core_pkg::reg_addr_w-1:0] addr3,
  input  logic                            write_en,
  input  logic [core_pkg::xlen-1:0]       write_data,
  output logic [core_pkg::xlen-1:0]       read1,
  output logic [core_pkg::xlen-1:0]       read2
);

  logic [core_pkg::xlen-1:0] regs [0:31];

  // x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && addr3 != '0) begin
      regs[addr3] <= write_data;
    end
  end

  // async reads, x0 forced to zero
  assign read1 = (addr1 == '0) ? '0 : regs[addr1];
  assign read2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [core_pkg::xlen-1:0] a,
  input  logic [core_pkg::xlen-1:0] b,
  input  core_pkg::alu_op_t         op,
  output logic [core_pkg::xlen-1:0] result,
  output logic                      zero
);

  always_comb begin
    case (op)
      core_pkg::alu_add: result = a + b;
      core_pkg::alu_sub: result = a - b;
      core_pkg::alu_and: result = a & b;
      core_pkg::alu_or:  result = a | b;
      // signed compare, result is 0 or 1
      core_pkg::alu_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:           result = '0;
    endcase
  end

  // branch compare reads this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::opcode_t     opcode,
  input  logic [2:0]            funct3,
  input  logic                  zero,
  output logic                  pc_update,
  output logic                  ir_write,
  output logic                  reg_write,
  output logic [3:0]            mem_write,
  output core_pkg::adr_src_t    adr_src,
  output core_pkg::alu_src_a_t  alu_src_a,
  output core_pkg::alu_src_b_t  alu_src_b,
  output core_pkg::result_src_t result_src,
  output logic                  alu_add
);

  core_pkg::state_t state;
  core_pkg::state_t next_state;
  logic             taken;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= core_pkg::st_fetch;
    end else begin
      state <= next_state;
    end
  end

  // next state
  always_comb begin
    next_state = core_pkg::st_fetch;
    case (state)
      core_pkg::st_fetch: next_state = core_pkg::st_decode;
      core_pkg::st_decode: begin
        case (opcode)
          core_pkg::op_lui:    next_state = core_pkg::st_lui;
          core_pkg::op_imm:    next_state = core_pkg::st_exec_i;
          core_pkg::op_reg:    next_state = core_pkg::st_exec_r;
          core_pkg::op_load:   next_state = core_pkg::st_mem_adr;
          core_pkg::op_store:  next_state = core_pkg::st_mem_adr;
          core_pkg::op_branch: next_state = core_pkg::st_branch;
          core_pkg::op_jal:    next_state = core_pkg::st_jal;
          // unknown opcode, skip it
          default:             next_state = core_pkg::st_fetch;
        endcase
      end
      core_pkg::st_mem_adr:
        next_state = (opcode == core_pkg::op_load) ? core_pkg::st_mem_read : core_pkg::st_mem_write;
      core_pkg::st_mem_read: next_state = core_pkg::st_mem_wb;
      core_pkg::st_exec_r:   next_state = core_pkg::st_alu_wb;
      core_pkg::st_exec_i:   next_state = core_pkg::st_alu_wb;
      default:               next_state = core_pkg::st_fetch;
    endcase
  end

  // bne inverts the zero test
  always_comb begin
    case (funct3)
      core_pkg::f3_beq: taken = zero;
      core_pkg::f3_bne: taken = !zero;
      default:          taken = 1'b0;
    endcase
  end

  // strobes and selects per state
  always_comb begin
    pc_update  = 1'b0;
    ir_write   = 1'b0;
    reg_write  = 1'b0;
    mem_write  = 4'b0000;
    adr_src    = core_pkg::adr_pc;
    alu_src_a  = core_pkg::src_a_pc;
    alu_src_b  = core_pkg::src_b_four;
    result_src = core_pkg::res_alu_out;
    alu_add    = 1'b0;
    case (state)
      core_pkg::st_fetch: begin
        // no fetch while held in reset
        ir_write = !reset;
        alu_add  = 1'b1;
      end
      core_pkg::st_decode: begin
        // branch or jump target into alu_out
        alu_src_a = core_pkg::src_a_old_pc;
        alu_src_b = core_pkg::src_b_imm;
        alu_add   = 1'b1;
      end
      core_pkg::st_mem_adr: begin
        alu_src_a = core_pkg::src_a_rd1;
        alu_src_b = core_pkg::src_b_imm;
        alu_add   = 1'b1;
      end
      core_pkg::st_mem_read: adr_src = core_pkg::adr_result;
      core_pkg::st_mem_wb: begin
        result_src = core_pkg::res_data;
        reg_write  = 1'b1;
      end
      core_pkg::st_mem_write: begin
        adr_src   = core_pkg::adr_result;
        // word stores only
        mem_write = 4'b1111;
      end
      core_pkg::st_exec_r: begin
        alu_src_a = core_pkg::src_a_rd1;
        alu_src_b = core_pkg::src_b_rd2;
      end
      core_pkg::st_exec_i: begin
        alu_src_a = core_pkg::src_a_rd1;
        alu_src_b = core_pkg::src_b_imm;
      end
      core_pkg::st_alu_wb: reg_write = 1'b1;
      core_pkg::st_branch: begin
        alu_src_a = core_pkg::src_a_rd1;
        alu_src_b = core_pkg::src_b_rd2;
        pc_update = taken;
      end
      core_pkg::st_jal: begin
        // link is old pc + 4, target already in alu_out
        alu_src_a  = core_pkg::src_a_old_pc;
        alu_add    = 1'b1;
        result_src = core_pkg::res_alu_result;
        reg_write  = 1'b1;
        pc_update  = 1'b1;
      end
      core_pkg::st_lui: begin
        alu_src_a  = core_pkg::src_a_zero;
        alu_src_b  = core_pkg::src_b_imm;
        alu_add    = 1'b1;
        result_src = core_pkg::res_alu_result;
        reg_write  = 1'b1;
      end
      default: ;
    endcase
  end

  // a store pulse belongs to a store, follows its address step and lasts one cycle
  a_store_pulse: assert property (@(posedge clk) disable iff (reset)
    (mem_write != 4'b0000) |-> (opcode == core_pkg::op_store) &&
      ($past(state) == core_pkg::st_mem_adr) && ($past(mem_write) == 4'b0000))
    else $error("write enable outside a single store cycle after st_mem_adr");

endmodule

`default_nettype wire

// File: design/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [core_pkg::xlen-1:0] memory_read_data,
  output logic [core_pkg::xlen-1:0] memory_address,
  output logic [core_pkg::xlen-1:0] memory_write_data,
  output logic [3:0]                memory_write_enable
);

  logic                            pc_update, ir_write, reg_write, force_add;
  core_pkg::adr_src_t              adr_src;
  core_pkg::alu_src_a_t            alu_src_a;
  core_pkg::alu_src_b_t            alu_src_b;
  core_pkg::result_src_t           result_src;
  core_pkg::opcode_t               opcode;
  core_pkg::alu_op_t               alu_op, alu_sel;
  logic [2:0]                      funct3;
  logic [core_pkg::reg_addr_w-1:0] rs1, rs2, rd;
  logic [core_pkg::xlen-1:0]       pc_cur, pc_old, instr, imm_ext;
  logic [core_pkg::xlen-1:0]       rd1, rd2, data_a, data_b, alu_out, data;
  logic [core_pkg::xlen-1:0]       src_a, src_b, alu_result, result;
  logic                            zero;

  // pc targets always come from alu_out
  fetch fetch_inst (.clk(clk), .reset(reset), .pc_update(pc_update), .ir_write(ir_write),
    .pc_next(alu_out), .read_data(memory_read_data), .pc_cur(pc_cur), .pc_old(pc_old),
    .instr(instr));

  instr_decode decode_inst (.instr(instr), .opcode(opcode), .funct3(funct3),
    .alu_op(alu_op), .imm_ext(imm_ext), .rs1(rs1), .rs2(rs2), .rd(rd));

  reg_file rf_inst (.clk(clk), .reset(reset), .addr1(rs1), .addr2(rs2), .addr3(rd),
    .write_en(reg_write), .write_data(result), .read1(rd1), .read2(rd2));

  control_fsm fsm_inst (.clk(clk), .reset(reset), .opcode(opcode), .funct3(funct3),
    .zero(zero), .pc_update(pc_update), .ir_write(ir_write), .reg_write(reg_write),
    .mem_write(memory_write_enable), .adr_src(adr_src), .alu_src_a(alu_src_a),
    .alu_src_b(alu_src_b), .result_src(result_src), .alu_add(force_add));

  // address and pc steps override the decoded op
  assign alu_sel = force_add ? core_pkg::alu_add : alu_op;

  alu alu_inst (.a(src_a), .b(src_b), .op(alu_sel), .result(alu_result), .zero(zero));

  always_comb begin
    case (alu_src_a)
      core_pkg::src_a_pc:     src_a = pc_cur;
      core_pkg::src_a_old_pc: src_a = pc_old;
      core_pkg::src_a_rd1:    src_a = data_a;
      default:                src_a = '0;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      core_pkg::src_b_rd2: src_b = data_b;
      core_pkg::src_b_imm: src_b = imm_ext;
      default:             src_b = core_pkg::word_step;
    endcase
  end

  // shared by writeback and the load or store address
  always_comb begin
    case (result_src)
      core_pkg::res_data:       result = data;
      core_pkg::res_alu_result: result = alu_result;
      default:                  result = alu_out;
    endcase
  end

  // one cycle staging between steps
  always_ff @(posedge clk) begin
    data_a  <= rd1;
    data_b  <= rd2;
    alu_out <= alu_result;
    data    <= memory_read_data;
  end

  assign memory_address    = (adr_src == core_pkg::adr_pc) ? pc_cur : result;
  assign memory_write_data = data_b;

endmodule

`default_nettype wire

// File: test/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam int reset_cycles = 5;
  localparam int tail_cycles  = 20;
  localparam int data_base    = 'h200;
  localparam int out_base     = 'h300;

  logic        clk;
  logic        reset;
  logic [31:0] memory_read_data;
  logic [31:0] memory_address;
  logic [31:0] memory_write_data;
  logic [3:0]  memory_write_enable;

  // memory and its load image
  logic [31:0] mem [0:255];
  logic [31:0] image [0:255];
  // register shadow and random data words
  logic [31:0] shadow [0:31];
  logic [31:0] rand_words [0:7];
  // expected store table
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_group [$];
  string       group_name [0:5];

  int prog_len;
  int store_off;
  int total_cycles;
  int cur_group;
  int cycle_limit;
  int cycle_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int seed;

  core_top core_inst (
    .clk(clk),
    .reset(reset),
    .memory_read_data(memory_read_data),
    .memory_address(memory_address),
    .memory_write_data(memory_write_data),
    .memory_write_enable(memory_write_enable)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // combinational read, byte lane writes, image copied in during reset
  assign memory_read_data = mem[memory_address[9:2]];
  always @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < 256; w++) begin
        mem[w] <= image[w];
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (memory_write_enable[b]) begin
          mem[memory_address[9:2]][8*b +: 8] <= memory_write_data[8*b +: 8];
        end
      end
    end
  end

  // run limit from the program length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: expected stores still missing after %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // rv32i encodings
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], core_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], core_pkg::op_store};
  endfunction

  function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                        input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            core_pkg::op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], core_pkg::op_jal};
  endfunction

  function automatic logic [31:0] enc_u(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], core_pkg::op_lui};
  endfunction

  function automatic logic [31:0] sext12(input int imm);
    return {{20{imm[11]}}, imm[11:0]};
  endfunction

  // isa result by funct3
  function automatic logic [31:0] expected_alu(input int f3, input bit sub,
                                               input logic [31:0] a, input logic [31:0] b);
    case (f3)
      0:       return sub ? a - b : a + b;
      2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6:       return a | b;
      7:       return a & b;
      default: return '0;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word, input int cycles);
    image[prog_len] = word;
    prog_len++;
    total_cycles += cycles;
  endtask

  // x0 stays zero
  task automatic set_reg(input int rd, input logic [31:0] value);
    if (rd != 0) shadow[rd] = value;
  endtask

  task automatic do_lui(input int rd, input int imm20);
    emit(enc_u(rd, imm20), 3);
    set_reg(rd, {imm20[19:0], 12'h000});
  endtask

  task automatic do_alu_i(input int f3, input int rd, input int rs1, input int imm);
    emit(enc_i(core_pkg::op_imm, f3, rd, rs1, imm), 4);
    set_reg(rd, expected_alu(f3, 1'b0, shadow[rs1], sext12(imm)));
  endtask

  task automatic do_alu_r(input int f3, input bit sub, input int rd, input int rs1,
                          input int rs2);
    emit(enc_r(sub ? 32 : 0, rs2, rs1, f3, rd), 4);
    set_reg(rd, expected_alu(f3, sub, shadow[rs1], shadow[rs2]));
  endtask

  task automatic do_lw(input int rd, input int rs1, input int off);
    logic [31:0] addr;
    int          idx;
    addr = shadow[rs1] + sext12(off);
    idx  = (addr - data_base) / 4;
    emit(enc_i(core_pkg::op_load, 2, rd, rs1, off), 5);
    set_reg(rd, rand_words[idx]);
  endtask

  // stores walk forward from x2, a skipped one still uses its slot
  task automatic do_sw(input int rs2, input bit runs);
    logic [31:0] addr;
    addr = shadow[2] + sext12(store_off);
    emit(enc_s(rs2, 2, store_off), 4);
    if (runs) begin
      exp_addr.push_back(addr);
      exp_data.push_back(shadow[rs2]);
      exp_group.push_back(cur_group);
    end
    store_off += 4;
  endtask

  // +8 hops over the marker store
  task automatic do_branch(input int f3, input int rs1, input int rs2, input int marker);
    bit taken;
    taken = (f3 == 0) ? (shadow[rs1] == shadow[rs2]) : (shadow[rs1] != shadow[rs2]);
    emit(enc_b(f3, rs1, rs2, 8), 3);
    do_sw(marker, !taken);
    do_sw(rs1, 1'b1);
  endtask

  task automatic do_jal(input int rd);
    logic [31:0] link;
    link = prog_len * 4 + 4;
    emit(enc_j(rd, 8), 3);
    set_reg(rd, link);
    do_sw(0, 1'b0);
    do_sw(rd, 1'b1);
  endtask

  task automatic build_program();
    cur_group = 0;
    do_alu_i(0, 2, 0, out_base);
    do_alu_i(0, 1, 0, data_base);
    do_lui(3, 'h12345);
    do_sw(3, 1'b1);
    do_alu_i(0, 3, 3, 'h678);
    do_sw(3, 1'b1);
    do_alu_i(0, 4, 3, -1);
    do_sw(4, 1'b1);
    do_alu_i(7, 5, 3, 'h0f0);
    do_sw(5, 1'b1);
    // 0x800 sign extends to a negative immediate
    do_alu_i(6, 6, 3, 'h800);
    do_sw(6, 1'b1);
    do_lui(7, 'hfffff);
    do_alu_i(6, 7, 7, 'h123);
    do_sw(7, 1'b1);
    cur_group = 1;
    do_lw(8, 1, 0);
    do_lw(9, 1, 4);
    do_alu_r(0, 1'b0, 10, 8, 9);
    do_sw(10, 1'b1);
    do_alu_r(0, 1'b1, 10, 8, 9);
    do_sw(10, 1'b1);
    do_alu_r(7, 1'b0, 10, 8, 9);
    do_sw(10, 1'b1);
    do_alu_r(6, 1'b0, 10, 8, 9);
    do_sw(10, 1'b1);
    do_alu_r(2, 1'b0, 10, 8, 9);
    do_sw(10, 1'b1);
    do_alu_r(2, 1'b0, 10, 9, 8);
    do_sw(10, 1'b1);
    // both operands negative
    do_lui(11, 'hfffff);
    do_alu_i(0, 12, 0, -5);
    do_alu_r(2, 1'b0, 10, 11, 12);
    do_sw(10, 1'b1);
    do_alu_r(2, 1'b0, 10, 12, 11);
    do_sw(10, 1'b1);
    do_alu_i(2, 10, 12, -4);
    do_sw(10, 1'b1);
    cur_group = 2;
    for (int k = 0; k < 8; k++) begin
      do_lw(13, 1, 4 * k);
      do_sw(13, 1'b1);
    end
    cur_group = 3;
    do_alu_i(0, 14, 0, 5);
    do_alu_i(0, 15, 0, 5);
    do_alu_i(0, 16, 0, 7);
    do_alu_i(0, 17, 0, 'h5a5);
    do_branch(0, 14, 15, 17);
    do_branch(0, 14, 16, 17);
    do_branch(1, 14, 16, 17);
    do_branch(1, 14, 15, 17);
    cur_group = 4;
    do_jal(18);
    do_jal(19);
    cur_group = 5;
    do_alu_i(0, 0, 0, 'h123);
    do_sw(0, 1'b1);
    do_alu_r(6, 1'b0, 0, 3, 7);
    do_sw(0, 1'b1);
    do_lui(0, 'habcde);
    do_sw(0, 1'b1);
    // park on a jump to itself
    emit(enc_j(0, 0), 3);
  endtask

  initial begin
    int errs;
    int group_stores;
    int group_fails;
    reset = 1'b1;
    seed = 76;
    prog_len = 0;
    store_off = 0;
    total_cycles = 0;
    group_stores = 0;
    group_fails = 0;
    group_name[0] = "lui and immediates";
    group_name[1] = "register alu";
    group_name[2] = "load and store";
    group_name[3] = "branches";
    group_name[4] = "jal";
    group_name[5] = "x0 writes";
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    // filler from the full word address
    for (int w = 0; w < 256; w++) begin
      image[w] = ~(w * 32'h9e37_79b9);
    end
    for (int k = 0; k < 8; k++) begin
      rand_words[k] = $random(seed);
      image[data_base / 4 + k] = rand_words[k];
    end
    build_program();
    cycle_limit = 2 * total_cycles + reset_cycles + tail_cycles;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < exp_addr.size(); i++) begin
      // next store pulse
      do @(negedge clk); while (memory_write_enable == 4'b0000);
      errs = 0;
      if (memory_address !== exp_addr[i]) begin
        $display("Error: memory_address %h, expected %h (store %0d)",
                 memory_address, exp_addr[i], i);
        errs++;
      end
      if (memory_write_data !== exp_data[i]) begin
        $display("Error: memory_write_data %h, expected %h (store %0d)",
                 memory_write_data, exp_data[i], i);
        errs++;
      end
      if (memory_write_enable !== 4'hf) begin
        $display("Error: memory_write_enable %h, expected f (store %0d)",
                 memory_write_enable, i);
        errs++;
      end
      if (errs == 0) pass_count++;
      else fail_count++;
      group_stores++;
      if (errs != 0) group_fails++;
      // group done
      if (i == exp_addr.size() - 1 || exp_group[i + 1] != exp_group[i]) begin
        $display("%-20s %0d stores, %0d wrong", group_name[exp_group[i]],
                 group_stores, group_fails);
        group_stores = 0;
        group_fails = 0;
      end
    end
    // the self loop must stay quiet
    repeat (tail_cycles) begin
      @(negedge clk);
      if (memory_write_enable != 4'b0000) begin
        $display("unexpected store to address %h after the last expected store",
                 memory_address);
        fail_count++;
      end
    end
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
design/core_pkg.sv
design/fetch.sv
design/instr_decode.sv
design/reg_file.sv
design/alu.sv
design/control_fsm.sv
design/core_top.sv
test/tb_core.sv

// File: run.sh
#!/bin/bash
# build with verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_core -o sim_tb_core \
  && ./obj_dir/sim_tb_core | tee sim.log \
  && grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
